// File: include/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Operand and result width
`define ALU_WIDTH 16

// Operand FIFO entries
`define ALU_FIFO_DEPTH 4

// Carry scheme of the adder
// 0 selects ripple carry, 1 selects carry lookahead
`define ALU_USE_CLA 1

`endif

// File: hdl/alu_op_pkg.sv
package alu_op_pkg;

    // Command opcodes
    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_SUB = 2'b01,
        OP_ADC = 2'b10,
        OP_SBB = 2'b11
    } alu_opcode_t;

    // Where the adder carry-in comes from
    // CARRY_FIXED uses the bit stored with the entry, CARRY_FLAG the kept carry
    typedef enum logic {
        CARRY_FIXED = 1'b0,
        CARRY_FLAG  = 1'b1
    } carry_src_t;

endpackage

// File: hdl/alu_data_pkg.sv
`include "alu_config.svh"

package alu_data_pkg;

    // One operand or sum word
    typedef logic [`ALU_WIDTH-1:0] word_t;

    // Sum with the carry-out bit on top
    typedef logic [`ALU_WIDTH:0] sum_ext_t;

endpackage

// File: hdl/cmd_decode.sv
`timescale 1ns/10ps

module cmd_decode
    import alu_op_pkg::*;
    import alu_data_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  alu_opcode_t opcode,
    input  word_t       a,
    input  word_t       b,
    output logic        push,
    output word_t       op_a,
    output word_t       op_b,
    output logic        cin_fixed,
    output carry_src_t  carry_src
);

    word_t      b_dec;
    logic       cin_dec;
    carry_src_t src_dec;

    // Subtracts invert b; the +1 comes from cin or from the carry flag
    always_comb begin
        b_dec   = b;
        cin_dec = 1'b0;
        src_dec = CARRY_FIXED;
        case (opcode)
            OP_ADD: begin
                b_dec   = b;
                cin_dec = 1'b0;
                src_dec = CARRY_FIXED;
            end
            OP_SUB: begin
                b_dec   = ~b;
                cin_dec = 1'b1;
                src_dec = CARRY_FIXED;
            end
            OP_ADC: begin
                b_dec   = b;
                src_dec = CARRY_FLAG;
            end
            OP_SBB: begin
                b_dec   = ~b;
                src_dec = CARRY_FLAG;
            end
            default: begin
                b_dec   = b;
                src_dec = CARRY_FIXED;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= cmd_valid;
        end
    end

    // Operand capture, only meaningful while push is high
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            op_a      <= a;
            op_b      <= b_dec;
            cin_fixed <= cin_dec;
            carry_src <= src_dec;
        end
    end

endmodule

// File: hdl/operand_fifo.sv
`timescale 1ns/10ps

`include "alu_config.svh"

module operand_fifo
    import alu_op_pkg::*;
    import alu_data_pkg::*;
#(
    parameter int DEPTH = `ALU_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  word_t      op_a_in,
    input  word_t      op_b_in,
    input  logic       cin_in,
    input  carry_src_t carry_src_in,
    input  logic       pop,
    output word_t      op_a,
    output word_t      op_b,
    output logic       cin,
    output carry_src_t carry_src,
    output logic       empty,
    output logic       full,
    output logic       dropped
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t      mem_a   [DEPTH];
    word_t      mem_b   [DEPTH];
    logic       mem_cin [DEPTH];
    carry_src_t mem_src [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    // Wrap explicitly so any depth works, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    assign pop_ok = pop && !empty;
    // A full FIFO still takes a push when the head leaves at the same edge
    assign push_ok = push && (!full || pop_ok);

    assign op_a      = mem_a[rd_ptr];
    assign op_b      = mem_b[rd_ptr];
    assign cin       = mem_cin[rd_ptr];
    assign carry_src = mem_src[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_a[wr_ptr]   <= op_a_in;
            mem_b[wr_ptr]   <= op_b_in;
            mem_cin[wr_ptr] <= cin_in;
            mem_src[wr_ptr] <= carry_src_in;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            dropped <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            dropped <= push && !push_ok;
        end
    end

endmodule

// File: hdl/adder_16bit.sv
`timescale 1ns/10ps

`include "alu_config.svh"

module adder_16bit
    import alu_data_pkg::*;
#(
    parameter int USE_CARRY_LOOKAHEAD = `ALU_USE_CLA
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  load,
    input  word_t a,
    input  word_t b,
    input  logic  cin,
    output word_t sum,
    output logic  cout,
    output logic  overflow
);

    localparam int W = $bits(word_t);

    // c[i] is the carry into bit i, c[W] the carry-out
    logic [W:0] c;
    word_t      sum_c;
    logic       ovf_c;

    generate
        if (USE_CARRY_LOOKAHEAD != 0) begin : g_lookahead
            word_t g;
            word_t p;

            assign g = a & b;
            assign p = a ^ b;

            // Each carry is a flat sum of products of g, p and cin
            always_comb begin
                logic gen_acc;
                logic prop_acc;
                c[0] = cin;
                for (int i = 0; i < W; i++) begin
                    gen_acc  = g[i];
                    prop_acc = p[i];
                    for (int j = i - 1; j >= 0; j--) begin
                        gen_acc  = gen_acc | (prop_acc & g[j]);
                        prop_acc = prop_acc & p[j];
                    end
                    c[i+1] = gen_acc | (prop_acc & cin);
                end
            end
        end else begin : g_ripple
            assign c[0] = cin;
            for (genvar i = 0; i < W; i++) begin : g_bit
                assign c[i+1] = (a[i] & b[i]) | (a[i] & c[i]) | (b[i] & c[i]);
            end
        end
    endgenerate

    assign sum_c = a ^ b ^ c[W-1:0];

    // Same-sign operands with a sum of the other sign
    assign ovf_c = (a[W-1] == b[W-1]) && (sum_c[W-1] != a[W-1]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum      <= '0;
            cout     <= 1'b0;
            overflow <= 1'b0;
        end else if (load) begin
            sum      <= sum_c;
            cout     <= c[W];
            overflow <= ovf_c;
        end
    end

endmodule

// File: hdl/result_stage.sv
`timescale 1ns/10ps

`include "alu_config.svh"

module result_stage
    import alu_op_pkg::*;
    import alu_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       hold,
    input  logic       empty,
    input  word_t      op_a,
    input  word_t      op_b,
    input  logic       cin_fixed,
    input  carry_src_t carry_src,
    output logic       pop,
    output logic       result_valid,
    output word_t      sum,
    output logic       cout,
    output logic       overflow
);

    logic carry_flag;
    logic cin_sel;

    // Take the head whenever one is there and we are not held off
    assign pop = !empty && !hold;

    // The adder's registered carry-out only changes on a load, so it is
    // the carry flag kept between operations
    assign carry_flag = cout;

    // ADC and SBB chain on the previous result's carry
    assign cin_sel = (carry_src == CARRY_FLAG) ? carry_flag : cin_fixed;

    adder_16bit #(
        .USE_CARRY_LOOKAHEAD(`ALU_USE_CLA)
    ) i_adder (
        .clk      (clk),
        .rst      (rst),
        .load     (pop),
        .a        (op_a),
        .b        (op_b),
        .cin      (cin_sel),
        .sum      (sum),
        .cout     (cout),
        .overflow (overflow)
    );

    // New sum is on the adder outputs the cycle after the pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= pop;
        end
    end

endmodule

// File: hdl/alu_top.sv
`timescale 1ns/10ps

`include "alu_config.svh"

module alu_top
    import alu_op_pkg::*;
    import alu_data_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  alu_opcode_t opcode,
    input  word_t       a,
    input  word_t       b,
    input  logic        hold,
    output logic        result_valid,
    output word_t       sum,
    output logic        cout,
    output logic        overflow,
    output logic        busy,
    output logic        cmd_dropped
);

    // Decoder to FIFO
    logic       dec_push;
    word_t      dec_a;
    word_t      dec_b;
    logic       dec_cin;
    carry_src_t dec_src;

    // FIFO head to result stage
    word_t      head_a;
    word_t      head_b;
    logic       head_cin;
    carry_src_t head_src;
    logic       fifo_empty;
    logic       fifo_pop;

    cmd_decode i_decode (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .opcode    (opcode),
        .a         (a),
        .b         (b),
        .push      (dec_push),
        .op_a      (dec_a),
        .op_b      (dec_b),
        .cin_fixed (dec_cin),
        .carry_src (dec_src)
    );

    // busy is the full flag
    operand_fifo #(
        .DEPTH(`ALU_FIFO_DEPTH)
    ) i_fifo (
        .clk          (clk),
        .rst          (rst),
        .push         (dec_push),
        .op_a_in      (dec_a),
        .op_b_in      (dec_b),
        .cin_in       (dec_cin),
        .carry_src_in (dec_src),
        .pop          (fifo_pop),
        .op_a         (head_a),
        .op_b         (head_b),
        .cin          (head_cin),
        .carry_src    (head_src),
        .empty        (fifo_empty),
        .full         (busy),
        .dropped      (cmd_dropped)
    );

    result_stage i_result (
        .clk          (clk),
        .rst          (rst),
        .hold         (hold),
        .empty        (fifo_empty),
        .op_a         (head_a),
        .op_b         (head_b),
        .cin_fixed    (head_cin),
        .carry_src    (head_src),
        .pop          (fifo_pop),
        .result_valid (result_valid),
        .sum          (sum),
        .cout         (cout),
        .overflow     (overflow)
    );

endmodule

// File: tb/alu_top_tb.sv
`timescale 1ns/10ps

`include "alu_config.svh"

module alu_top_tb
    import alu_op_pkg::*;
    import alu_data_pkg::*;
();

    localparam int NUM_PAT = 23;
    localparam int COLS    = 7;
    localparam int DEPTH   = `ALU_FIFO_DEPTH;
    localparam int TIMEOUT = 50;
    localparam int W       = `ALU_WIDTH;

    logic        clk = 1'b0;
    logic        rst;
    logic        cmd_valid;
    alu_opcode_t opcode;
    word_t       a;
    word_t       b;
    logic        hold;
    logic        result_valid;
    word_t       sum;
    logic        cout;
    logic        overflow;
    logic        busy;
    logic        cmd_dropped;

    logic [31:0]  pat_mem [NUM_PAT*COLS];
    // Expected {overflow, cout, sum} per command in issue order
    logic [W+1:0] exp_q [$];
    logic         model_carry;
    int           err_cnt;
    int           check_cnt;
    int           drop_cnt;
    logic         busy_seen;
    logic         monitor_on;

    alu_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .opcode       (opcode),
        .a            (a),
        .b            (b),
        .hold         (hold),
        .result_valid (result_valid),
        .sum          (sum),
        .cout         (cout),
        .overflow     (overflow),
        .busy         (busy),
        .cmd_dropped  (cmd_dropped)
    );

    always #4 clk = ~clk;

    // Back-pressure monitor on the falling edge
    always @(negedge clk) begin
        if (monitor_on) begin
            if (cmd_dropped) begin
                drop_cnt++;
            end
            if (busy) begin
                busy_seen = 1'b1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_cnt++;
        if (got !== expected) begin
            $display("FAIL %0t ns %s: got %h, expected %h", $time, name, got, expected);
            err_cnt++;
        end
    endtask

    // Subtracts add the inverse of b; ADC and SBB take the previous carry
    function automatic logic [W+1:0] expected_result(input alu_opcode_t op, input word_t x,
                                                     input word_t y, input logic carry);
        word_t    y_eff;
        logic     c_in;
        sum_ext_t ext;
        int       signed_sum;
        logic     ovf;
        y_eff = (op == OP_SUB || op == OP_SBB) ? ~y : y;
        c_in  = (op == OP_ADD) ? 1'b0 : ((op == OP_SUB) ? 1'b1 : carry);
        ext   = sum_ext_t'(x) + sum_ext_t'(y_eff) + sum_ext_t'(c_in);
        // Overflow when the true signed result leaves the range of a word
        signed_sum = int'($signed(x)) + int'($signed(y_eff)) + int'(c_in);
        ovf        = (signed_sum > (2 ** (W - 1)) - 1) || (signed_sum < -(2 ** (W - 1)));
        return {ovf, ext};
    endfunction

    task automatic report_test(input string name, input int errs);
        $display("Test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "mismatch", errs);
    endtask

    // Cross-check one pattern line against the rules and issue it
    task automatic send_pattern(input int idx, input logic executed);
        alu_opcode_t  op;
        logic [W+1:0] file_res;
        logic [W+1:0] calc_res;
        op       = alu_opcode_t'(pat_mem[idx*COLS][1:0]);
        file_res = {pat_mem[idx*COLS+6][0], pat_mem[idx*COLS+5][0],
                    pat_mem[idx*COLS+4][W-1:0]};
        calc_res = expected_result(op, pat_mem[idx*COLS+1][W-1:0],
                                   pat_mem[idx*COLS+2][W-1:0], model_carry);
        check_value("pattern file vs model", file_res, calc_res);
        if (executed) begin
            model_carry = calc_res[W];
            exp_q.push_back(file_res);
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        opcode    = op;
        a         = pat_mem[idx*COLS+1][W-1:0];
        b         = pat_mem[idx*COLS+2][W-1:0];
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // Wait for the next result_valid and compare with the oldest expected result
    task automatic collect_result();
        logic         seen;
        logic [W+1:0] exp_res;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = result_valid;
        end
        if (!seen) begin
            $display("Timeout: no result_valid within %0d cycles at %0t ns", TIMEOUT, $time);
            err_cnt++;
        end else if (exp_q.size() == 0) begin
            $display("Unexpected result at %0t ns with no command outstanding", $time);
            err_cnt++;
        end else begin
            exp_res = exp_q.pop_front();
            check_value("sum", sum, exp_res[W-1:0]);
            check_value("cout", cout, exp_res[W]);
            check_value("overflow", overflow, exp_res[W+1]);
        end
    endtask

    task automatic run_sequential(input string name, input int first, input int count);
        int errs;
        errs = err_cnt;
        for (int i = first; i < first + count; i++) begin
            send_pattern(i, 1'b1);
            collect_result();
        end
        report_test(name, err_cnt - errs);
    endtask

    // Commands past the FIFO depth are lost while hold is high
    task automatic run_burst(input string name, input int first, input int count);
        int errs;
        int extra;
        errs       = err_cnt;
        extra      = 0;
        drop_cnt   = 0;
        busy_seen  = 1'b0;
        monitor_on = 1'b1;
        @(posedge clk);
        #1;
        hold = 1'b1;
        for (int i = 0; i < count; i++) begin
            send_pattern(first + i, i < DEPTH);
            repeat (pat_mem[(first + i)*COLS+3]) @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #1;
        hold = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            collect_result();
        end
        repeat (DEPTH + 2) begin
            @(negedge clk);
            if (result_valid) begin
                extra++;
            end
        end
        monitor_on = 1'b0;
        check_value("results after burst drained", extra, 0);
        check_value("cmd_dropped pulses", drop_cnt, 1);
        check_value("busy seen high", busy_seen, 1'b1);
        report_test(name, err_cnt - errs);
    endtask

    initial begin
        int errs;
        cmd_valid   = 1'b0;
        opcode      = OP_ADD;
        a           = '0;
        b           = '0;
        hold        = 1'b0;
        rst         = 1'b1;
        err_cnt     = 0;
        check_cnt   = 0;
        drop_cnt    = 0;
        busy_seen   = 1'b0;
        monitor_on  = 1'b0;
        model_carry = 1'b0;
        $readmemh("tb/alu_patterns.txt", pat_mem);
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        errs = err_cnt;
        check_value("result_valid", result_valid, 0);
        check_value("busy", busy, 0);
        check_value("cmd_dropped", cmd_dropped, 0);
        check_value("sum", sum, 0);
        check_value("cout", cout, 0);
        check_value("overflow", overflow, 0);
        report_test("reset state", err_cnt - errs);
        run_sequential("add and sub", 0, 6);
        run_sequential("adc and sbb chains", 6, 6);
        run_sequential("signed overflow", 12, 6);
        run_burst("back-pressure", 18, 5);
        check_value("results still outstanding", exp_q.size(), 0);
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
hdl/alu_op_pkg.sv
hdl/alu_data_pkg.sv
hdl/cmd_decode.sv
hdl/operand_fifo.sv
hdl/adder_16bit.sv
hdl/result_stage.sv
hdl/alu_top.sv
tb/alu_top_tb.sv

// File: tb/alu_patterns.txt
// Columns: opcode (0 ADD, 1 SUB, 2 ADC, 3 SBB), a, b, hold cycles,
// expected sum, expected carry, expected overflow
// ADD and SUB
0 1234 1111 0 2345 0 0
0 ffff 0001 0 0000 1 0
0 a0b0 6f50 0 1000 1 0
1 5000 2000 0 3000 1 0
1 2000 5000 0 d000 0 0
1 1234 1234 0 0000 1 0
// 32-bit add 12348000 + 0fff9000, 32-bit subtract 00051000 - 00022000
0 8000 9000 0 1000 1 1
2 1234 0fff 0 2234 0 0
1 1000 2000 0 f000 0 0
3 0005 0002 0 0002 1 0
2 0000 0000 0 0001 0 0
3 0000 0000 0 ffff 0 0
// Signed overflow
0 7fff 0001 0 8000 0 1
0 8000 8000 0 0000 1 1
0 7fff ffff 0 7ffe 1 0
1 8000 0001 0 7fff 1 1
1 7fff ffff 0 8000 0 1
0 4000 3fff 0 7fff 0 0
// Burst under hold, the last one finds the FIFO full
0 0100 0200 1 0300 0 0
1 0300 0100 1 0200 1 0
0 f000 2000 1 1000 1 0
0 6000 6000 1 c000 0 1
0 0011 0022 1 0033 0 0
